// File: design/ccip_pkg.sv
// Host interface definitions for the simplified CCI-P MMIO path
// Covers the MMIO request header and the Rx and Tx port structures

package ccip_pkg;

    // ========================================
    // Field widths
    // ========================================

    localparam int MMIO_ADDR_W = 16;
    localparam int MMIO_TID_W  = 9;
    localparam int MMIO_DATA_W = 64;

    typedef logic [MMIO_ADDR_W-1:0] t_ccip_mmio_addr;
    typedef logic [MMIO_TID_W-1:0]  t_ccip_tid;
    typedef logic [MMIO_DATA_W-1:0] t_ccip_data;

    // ========================================
    // MMIO request header
    // ========================================

    // Word address and transaction id of one MMIO access
    typedef struct packed {
        t_ccip_mmio_addr address;
        t_ccip_tid       tid;
    } t_ccip_mmio_hdr;

    // ========================================
    // Port structures
    // ========================================

    // Host to AFU
    // Write and read strobes are never high together
    typedef struct packed {
        logic           mmio_wr_valid;
        logic           mmio_rd_valid;
        t_ccip_mmio_hdr hdr;
        t_ccip_data     data;
    } t_if_ccip_rx;

    // AFU to host
    // Read response, no back-pressure from the host
    typedef struct packed {
        logic       mmio_rsp_valid;
        t_ccip_tid  tid;
        t_ccip_data data;
    } t_if_ccip_tx;

endpackage

// File: design/afu_pkg.sv
// AFU definitions for the checksum lanes
// Lane count, CSR map, identifier, lane opcodes and lane command/response

package afu_pkg;

    // ========================================
    // Sizing and CSR map
    // ========================================

    // Any power of two up to 16
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // Identifier read back at word address 0
    localparam ccip_pkg::t_ccip_data      AFU_ID      = 64'hC5A7_3E19_0B42_D6F1;
    localparam ccip_pkg::t_ccip_mmio_addr AFU_ID_ADDR = 16'd0;

    // Lane window starts here, four words per lane
    localparam ccip_pkg::t_ccip_mmio_addr LANE_BASE = 16'd16;
    localparam ccip_pkg::t_ccip_mmio_addr LANE_SPAN = 16'(4 * NUM_LANES);

    // Register number inside a lane window
    localparam logic [1:0] REG_SUM   = 2'd0;
    localparam logic [1:0] REG_COUNT = 2'd1;

    // ========================================
    // Lane command and response
    // ========================================

    typedef enum logic [2:0] {
        LANE_NOP,
        LANE_ACCUM,
        LANE_CLEAR,
        LANE_RD_SUM,
        LANE_RD_COUNT
    } t_lane_op;

    typedef struct packed {
        t_lane_op             op;
        ccip_pkg::t_ccip_data data;
        ccip_pkg::t_ccip_tid  tid;
    } t_lane_cmd;

    typedef struct packed {
        logic                 valid;
        ccip_pkg::t_ccip_tid  tid;
        ccip_pkg::t_ccip_data data;
    } t_lane_rsp;

endpackage

// File: design/afu_lane.sv
// Checksum lane
// Keeps a rotate-and-XOR checksum and a word count, answers reads
// one cycle after the command

`timescale 1ns/1ps

module afu_lane
(
    input  logic               pClk,
    input  logic               rst_n,
    input  afu_pkg::t_lane_cmd cmd,
    output afu_pkg::t_lane_rsp rsp
);
    import ccip_pkg::*;
    import afu_pkg::*;

    // Lane state
    t_ccip_data  sum_q;
    logic [31:0] count_q;

    // Read response register
    logic        rsp_vld_q;
    t_ccip_tid   rsp_tid_q;
    t_ccip_data  rsp_data_q;
    logic        is_read;

    assign is_read = (cmd.op == LANE_RD_SUM) || (cmd.op == LANE_RD_COUNT);

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sum_q     <= '0;
            count_q   <= '0;
            rsp_vld_q <= 1'b0;
        end
        else
        begin
            case (cmd.op)
                LANE_ACCUM:
                begin
                    // Rotate left one bit, then fold in the new word
                    sum_q   <= {sum_q[62:0], sum_q[63]} ^ cmd.data;
                    count_q <= count_q + 32'd1;
                end
                LANE_CLEAR:
                begin
                    sum_q   <= '0;
                    count_q <= '0;
                end
                default:
                begin
                    sum_q   <= sum_q;
                    count_q <= count_q;
                end
            endcase
            rsp_vld_q <= is_read;
        end
    end

    // State already holds any write from the cycle before
    always_ff @(posedge pClk)
    begin
        if (is_read)
        begin
            rsp_tid_q  <= cmd.tid;
            rsp_data_q <= (cmd.op == LANE_RD_SUM) ? sum_q : {32'd0, count_q};
        end
    end

    assign rsp = '{valid: rsp_vld_q, tid: rsp_tid_q, data: rsp_data_q};

endmodule

// File: design/afu_csr_dispatch.sv
// MMIO dispatcher for the checksum AFU
// Turns each registered request into one lane command and answers
// identifier and unmapped reads on the global response path

`timescale 1ns/1ps

module afu_csr_dispatch
(
    input  logic                                        pClk,
    input  logic                                        rst_n,
    input  ccip_pkg::t_if_ccip_rx                       rx_q,
    output afu_pkg::t_lane_cmd [afu_pkg::NUM_LANES-1:0] lane_cmd,
    output afu_pkg::t_lane_rsp                          glob_rsp
);
    import ccip_pkg::*;
    import afu_pkg::*;

    // Address decode
    t_ccip_mmio_addr       offset;
    logic                  in_lanes;
    logic [LANE_IDX_W-1:0] lane_sel;
    logic [1:0]            reg_sel;
    t_lane_op              op_d;
    logic                  glob_hit;
    t_ccip_data            glob_data_d;

    // Command stage, payload shared by all lanes
    t_lane_op   op_q [NUM_LANES];
    t_ccip_data data_q;
    t_ccip_tid  tid_q;

    // Global response, two stages to line up with the lanes
    logic       glob_vld_q;
    logic       glob_vld_qq;
    t_ccip_data glob_data_q;
    t_ccip_data glob_data_qq;
    t_ccip_tid  glob_tid_qq;

    always_comb
    begin
        offset   = rx_q.hdr.address - LANE_BASE;
        in_lanes = (rx_q.hdr.address >= LANE_BASE) && (offset < LANE_SPAN);
        lane_sel = offset[2 +: LANE_IDX_W];
        reg_sel  = offset[1:0];

        op_d = LANE_NOP;
        if (in_lanes && rx_q.mmio_wr_valid)
        begin
            // Writes to reg 2 and 3 fall through as NOP
            if (reg_sel == REG_SUM)
                op_d = LANE_ACCUM;
            else if (reg_sel == REG_COUNT)
                op_d = LANE_CLEAR;
        end
        else if (in_lanes && rx_q.mmio_rd_valid)
        begin
            if (reg_sel == REG_SUM)
                op_d = LANE_RD_SUM;
            else if (reg_sel == REG_COUNT)
                op_d = LANE_RD_COUNT;
        end

        // Any read no lane takes is answered here
        glob_hit    = rx_q.mmio_rd_valid && (op_d == LANE_NOP);
        glob_data_d = (rx_q.hdr.address == AFU_ID_ADDR) ? AFU_ID : '0;
    end

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_LANES; i++)
                op_q[i] <= LANE_NOP;
            glob_vld_q  <= 1'b0;
            glob_vld_qq <= 1'b0;
        end
        else
        begin
            // Only the addressed lane sees a live opcode
            for (int i = 0; i < NUM_LANES; i++)
                op_q[i] <= (lane_sel == LANE_IDX_W'(i)) ? op_d : LANE_NOP;
            glob_vld_q  <= glob_hit;
            glob_vld_qq <= glob_vld_q;
        end
    end

    always_ff @(posedge pClk)
    begin
        data_q       <= rx_q.data;
        tid_q        <= rx_q.hdr.tid;
        glob_data_q  <= glob_data_d;
        glob_data_qq <= glob_data_q;
        glob_tid_qq  <= tid_q;
    end

    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
            lane_cmd[i] = '{op: op_q[i], data: data_q, tid: tid_q};
        glob_rsp = '{valid: glob_vld_qq, tid: glob_tid_qq, data: glob_data_qq};
    end

endmodule

// File: design/afu_resp_merge.sv
// Response merger
// ORs the lane and global responses into the registered Tx MMIO
// response and tracks any cycle with more than one response

`timescale 1ns/1ps

module afu_resp_merge
(
    input  logic                                        pClk,
    input  logic                                        rst_n,
    input  afu_pkg::t_lane_rsp [afu_pkg::NUM_LANES-1:0] lane_rsp,
    input  afu_pkg::t_lane_rsp                          glob_rsp,
    output ccip_pkg::t_if_ccip_tx                       tx
);
    import ccip_pkg::*;
    import afu_pkg::*;

    // Merged response
    logic       any_vld;
    t_ccip_tid  mrg_tid;
    t_ccip_data mrg_data;
    logic       clash;

    // Tx register and sticky collision flag
    logic       tx_vld_q;
    t_ccip_tid  tx_tid_q;
    t_ccip_data tx_data_q;
    logic       collision_q;

    always_comb
    begin
        any_vld  = glob_rsp.valid;
        mrg_tid  = glob_rsp.valid ? glob_rsp.tid : '0;
        mrg_data = glob_rsp.valid ? glob_rsp.data : '0;
        clash    = 1'b0;
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (lane_rsp[i].valid)
            begin
                // A second strobe in the same cycle is a collision
                if (any_vld)
                    clash = 1'b1;
                any_vld  = 1'b1;
                mrg_tid  = mrg_tid | lane_rsp[i].tid;
                mrg_data = mrg_data | lane_rsp[i].data;
            end
        end
    end

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tx_vld_q    <= 1'b0;
            collision_q <= 1'b0;
        end
        else
        begin
            tx_vld_q    <= any_vld;
            collision_q <= collision_q | clash;
        end
    end

    always_ff @(posedge pClk)
    begin
        tx_tid_q  <= mrg_tid;
        tx_data_q <= mrg_data;
    end

    assign tx = '{mmio_rsp_valid: tx_vld_q, tid: tx_tid_q, data: tx_data_q};

endmodule

// File: design/ccip_std_afu.sv
// Checksum AFU top level behind a CCI-P style MMIO port
// Registers Rx, synchronizes the host soft reset and wires the
// dispatcher, the lane array and the response merger

`timescale 1ns/1ps

module ccip_std_afu
(
    input  logic                  pClk,
    input  logic                  rst_n,
    input  logic                  soft_reset,
    input  ccip_pkg::t_if_ccip_rx rx,
    output ccip_pkg::t_if_ccip_tx tx
);
    import ccip_pkg::*;
    import afu_pkg::*;

    // ========================================
    // Soft reset synchronizer
    // ========================================

    // Three flop chain, preset while the board reset is low
    logic [2:0] soft_sync;
    logic       afu_rst_n;

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            soft_sync <= 3'b111;
        end
        else
        begin
            soft_sync <= {soft_sync[1:0], soft_reset};
        end
    end

    // Internal reset follows rst_n at once and soft_reset after three edges
    assign afu_rst_n = ~soft_sync[2];

    // ========================================
    // Rx input register
    // ========================================

    // Extra stage on the host side to relax timing
    t_if_ccip_rx rx_q;

    always_ff @(posedge pClk or negedge afu_rst_n)
    begin
        if (!afu_rst_n)
        begin
            // Only the strobes matter in reset
            rx_q.mmio_wr_valid <= 1'b0;
            rx_q.mmio_rd_valid <= 1'b0;
        end
        else
        begin
            rx_q <= rx;
        end
    end

    // ========================================
    // Functional model
    // ========================================

    t_lane_cmd [NUM_LANES-1:0] lane_cmd;
    t_lane_rsp [NUM_LANES-1:0] lane_rsp;
    t_lane_rsp                 glob_rsp;

    afu_csr_dispatch dispatch0
    (
        .pClk     (pClk),
        .rst_n    (afu_rst_n),
        .rx_q     (rx_q),
        .lane_cmd (lane_cmd),
        .glob_rsp (glob_rsp)
    );

    // One identical lane per slot in the CSR window
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        afu_lane lane0
        (
            .pClk  (pClk),
            .rst_n (afu_rst_n),
            .cmd   (lane_cmd[i]),
            .rsp   (lane_rsp[i])
        );
    end

    afu_resp_merge merge0
    (
        .pClk     (pClk),
        .rst_n    (afu_rst_n),
        .lane_rsp (lane_rsp),
        .glob_rsp (glob_rsp),
        .tx       (tx)
    );

endmodule

// File: tb/afu_properties.sv
// Assertions on the response merger
// Quiet Tx in reset, no response collisions, one cycle merge latency

`timescale 1ns/1ps

module afu_properties
(
    input logic                                        pClk,
    input logic                                        rst_n,
    input afu_pkg::t_lane_rsp [afu_pkg::NUM_LANES-1:0] lane_rsp,
    input afu_pkg::t_lane_rsp                          glob_rsp,
    input ccip_pkg::t_if_ccip_tx                       tx,
    input logic                                        collision
);
    import afu_pkg::*;

    // Any response strobe entering the merger
    logic rsp_in;

    always_comb
    begin
        rsp_in = glob_rsp.valid;
        for (int i = 0; i < NUM_LANES; i++)
            rsp_in = rsp_in | lane_rsp[i].valid;
    end

    a_quiet_in_reset: assert property (@(posedge pClk) !rst_n |-> !tx.mmio_rsp_valid)
        else $error("Tx response valid while the AFU is in reset");

    a_no_collision: assert property (@(posedge pClk) disable iff (!rst_n) !collision)
        else $error("Two responses reached the merger in the same cycle");

    // Each response leaves on the next edge
    a_rsp_forwarded: assert property
        (@(posedge pClk) disable iff (!rst_n) rsp_in |=> tx.mmio_rsp_valid)
        else $error("Response strobe was not forwarded to Tx one cycle later");

endmodule

bind afu_resp_merge afu_properties props0
(
    .pClk      (pClk),
    .rst_n     (rst_n),
    .lane_rsp  (lane_rsp),
    .glob_rsp  (glob_rsp),
    .tx        (tx),
    .collision (collision_q)
);

// File: tb/tb_ccip_std_afu.sv
// Testbench for the checksum AFU
// Drives LFSR driven MMIO traffic and checks every read response
// and its latency against a lane model

`timescale 1ns/1ps

module tb_ccip_std_afu;
    import ccip_pkg::*;
    import afu_pkg::*;

    localparam int RD_LATENCY = 4;
    localparam int WAIT_LIMIT = 200;
    localparam int RUN_LIMIT  = 20000;

    logic        pClk;
    logic        rst_n;
    logic        soft_reset;
    t_if_ccip_rx rx;
    t_if_ccip_tx tx;

    // LFSR state, cycle count and lane model
    logic [31:0] lfsr;
    int          cycle_cnt = 0;
    t_ccip_data  m_sum [NUM_LANES];
    logic [31:0] m_count [NUM_LANES];

    // Expected responses with the cycle each read was issued
    t_if_ccip_tx exp_q [$];
    int          issue_q [$];

    ccip_std_afu dut0
    (
        .pClk       (pClk),
        .rst_n      (rst_n),
        .soft_reset (soft_reset),
        .rx         (rx),
        .tx         (tx)
    );

    initial
    begin
        pClk = 1'b0;
        forever #4 pClk = ~pClk;
    end

    always @(posedge pClk)
        cycle_cnt <= cycle_cnt + 1;

    // ========================================
    // Random numbers and helpers
    // ========================================

    // Galois step, one call per bit taken
    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[62:0], next_bit()};
        return r;
    endfunction

    function automatic int rand_lane();
        return int'(rand_bits(4)) % NUM_LANES;
    endfunction

    function automatic t_ccip_tid rand_tid();
        return t_ccip_tid'(rand_bits(9));
    endfunction

    // Four words per lane above the lane base
    function automatic t_ccip_mmio_addr lane_addr(int lane, int reg_n);
        return LANE_BASE + t_ccip_mmio_addr'(lane * 4 + reg_n);
    endfunction

    // Lane index, or -1 outside the lane window
    function automatic int lane_of(t_ccip_mmio_addr addr);
        int off;
        off = int'(addr) - int'(LANE_BASE);
        if (off < 0 || off >= 4 * NUM_LANES)
            return -1;
        return off / 4;
    endfunction

    // Mix of low CSRs, unused lane regs, space above the window and any address
    function automatic t_ccip_mmio_addr odd_addr();
        int kind;
        kind = int'(rand_bits(2));
        if (kind == 0)
            return t_ccip_mmio_addr'(1 + int'(rand_bits(4)) % 15);
        if (kind == 1)
            return lane_addr(rand_lane(), 2 + int'(next_bit()));
        if (kind == 2)
            return lane_addr(NUM_LANES, 0) + t_ccip_mmio_addr'(rand_bits(8));
        return t_ccip_mmio_addr'(rand_bits(16));
    endfunction

    // ========================================
    // Checks
    // ========================================

    task automatic fail_run();
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_rsp(t_if_ccip_tx got, t_if_ccip_tx exp);
        if (got.tid !== exp.tid || got.data !== exp.data)
        begin
            $display("Mismatch at %0t: tid %0h data %h, expected tid %0h data %h",
                     $time, got.tid, got.data, exp.tid, exp.data);
            fail_run();
        end
    endtask

    task automatic check_latency(int got, int exp);
        if (got != exp)
        begin
            $display("Mismatch at %0t: response %0d cycles after its read, expected %0d",
                     $time, got, exp);
            fail_run();
        end
    endtask

    // Responses are sampled mid cycle away from the drive edge
    always @(negedge pClk)
    begin
        if (tx.mmio_rsp_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("A read response arrived at %0t with no read outstanding", $time);
                fail_run();
            end
            else
            begin
                check_latency(cycle_cnt - issue_q.pop_front(), RD_LATENCY);
                check_rsp(tx, exp_q.pop_front());
            end
        end
    end

    initial
    begin
        repeat (RUN_LIMIT) @(posedge pClk);
        $display("The simulation ran past its cycle limit without finishing");
        fail_run();
    end

    // ========================================
    // Drive tasks
    // ========================================

    task automatic idle_cycle();
        @(posedge pClk);
        #1;
        rx.mmio_wr_valid = 1'b0;
        rx.mmio_rd_valid = 1'b0;
    endtask

    task automatic mmio_write(t_ccip_mmio_addr addr, t_ccip_data data);
        int lane;
        int off;
        @(posedge pClk);
        #1;
        rx = '{mmio_wr_valid: 1'b1, mmio_rd_valid: 1'b0,
               hdr: '{address: addr, tid: '0}, data: data};
        lane = lane_of(addr);
        off  = int'(addr) - int'(LANE_BASE);
        // Reg 0 folds the word in, reg 1 clears, the rest is dropped
        if (lane >= 0 && off % 4 == 0)
        begin
            m_sum[lane]   = (m_sum[lane] << 1) | (m_sum[lane] >> 63);
            m_sum[lane]   = m_sum[lane] ^ data;
            m_count[lane] = m_count[lane] + 32'd1;
        end
        else if (lane >= 0 && off % 4 == 1)
        begin
            m_sum[lane]   = '0;
            m_count[lane] = '0;
        end
    endtask

    task automatic mmio_read(t_ccip_mmio_addr addr, t_ccip_tid tid);
        t_if_ccip_tx exp;
        int          lane;
        int          off;
        @(posedge pClk);
        #1;
        rx = '{mmio_wr_valid: 1'b0, mmio_rd_valid: 1'b1,
               hdr: '{address: addr, tid: tid}, data: '0};
        lane = lane_of(addr);
        off  = int'(addr) - int'(LANE_BASE);
        exp  = '{mmio_rsp_valid: 1'b1, tid: tid, data: '0};
        if (addr == AFU_ID_ADDR)
            exp.data = AFU_ID;
        else if (lane >= 0 && off % 4 == 0)
            exp.data = m_sum[lane];
        else if (lane >= 0 && off % 4 == 1)
            exp.data = {32'd0, m_count[lane]};
        exp_q.push_back(exp);
        issue_q.push_back(cycle_cnt);
    endtask

    // Sum and count of every lane, back to back
    task automatic read_all_lanes();
        for (int i = 0; i < NUM_LANES; i++)
        begin
            mmio_read(lane_addr(i, 0), rand_tid());
            mmio_read(lane_addr(i, 1), rand_tid());
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT)
        begin
            idle_cycle();
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Timed out with %0d read responses still missing", exp_q.size());
            fail_run();
        end
    endtask

    task automatic wait_afu_reset(logic level);
        int n;
        n = 0;
        while (dut0.afu_rst_n !== level && n < WAIT_LIMIT)
        begin
            idle_cycle();
            n++;
        end
        if (dut0.afu_rst_n !== level)
        begin
            $display("Timed out waiting for the internal reset to reach %0b", level);
            fail_run();
        end
    endtask

    task automatic pulse_soft_reset();
        idle_cycle();
        soft_reset = 1'b1;
        wait_afu_reset(1'b0);
        idle_cycle();
        soft_reset = 1'b0;
        for (int i = 0; i < NUM_LANES; i++)
        begin
            m_sum[i]   = '0;
            m_count[i] = '0;
        end
        wait_afu_reset(1'b1);
        // Quiet Tx window with no read outstanding
        repeat (8) idle_cycle();
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        int kind;
        lfsr       = 32'd94;
        rst_n      = 1'b0;
        soft_reset = 1'b0;
        rx         = '0;
        for (int i = 0; i < NUM_LANES; i++)
        begin
            m_sum[i]   = '0;
            m_count[i] = '0;
        end
        repeat (10) @(posedge pClk);
        #1;
        rst_n = 1'b1;
        wait_afu_reset(1'b1);

        // Identifier read
        mmio_read(AFU_ID_ADDR, rand_tid());
        wait_drained();

        // Accumulate into random lanes, then read sums and counts
        for (int i = 0; i < 40; i++)
        begin
            mmio_write(lane_addr(rand_lane(), 0), rand_bits(64));
            if (next_bit())
                idle_cycle();
        end
        read_all_lanes();
        wait_drained();

        // Clear one lane, others keep their state
        mmio_write(lane_addr(rand_lane(), 1), rand_bits(64));
        read_all_lanes();
        wait_drained();

        // Mixed traffic with reads right behind writes
        for (int i = 0; i < 300; i++)
        begin
            kind = int'(rand_bits(3));
            case (kind)
                0, 1, 2: mmio_write(lane_addr(rand_lane(), 0), rand_bits(64));
                3:       mmio_write(lane_addr(rand_lane(), 1), rand_bits(64));
                4, 5:    mmio_read(lane_addr(rand_lane(), 0), rand_tid());
                6:       mmio_read(lane_addr(rand_lane(), 1), rand_tid());
                default: mmio_read(AFU_ID_ADDR, rand_tid());
            endcase
        end
        wait_drained();

        // Unmapped reads and writes
        for (int i = 0; i < 60; i++)
        begin
            if (next_bit())
                mmio_write(odd_addr(), rand_bits(64));
            else
                mmio_read(odd_addr(), rand_tid());
        end
        read_all_lanes();
        wait_drained();

        // Soft reset clears every lane
        pulse_soft_reset();
        read_all_lanes();
        wait_drained();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: src.f
design/ccip_pkg.sv
design/afu_pkg.sv
design/afu_lane.sv
design/afu_csr_dispatch.sv
design/afu_resp_merge.sv
design/ccip_std_afu.sv
tb/afu_properties.sv
tb/tb_ccip_std_afu.sv

// File: run.sh
#!/bin/sh
# Compile and run the checksum AFU testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    -f src.f \
    --top-module tb_ccip_std_afu \
    -o sim_tb_ccip_std_afu

# The log is kept even when the run stops early, the search below decides
./obj_dir/sim_tb_ccip_std_afu > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
